/* flist.f */
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/decodeBus.sv
verilog/instrFetch.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/writeBack.sv
verilog/mips16Core.sv
testbench/clockGen.sv
testbench/mips16Tb.sv

/* testbench/clockGen.sv */
`timescale 1ns/10ps

module clockGen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk; // 10 ns period
	end

endmodule

/* testbench/mips16Tb.sv */
`timescale 1ns/10ps

module mips16Tb;

	localparam int maxRows = 64; // Fits the program memory
	localparam int addrBits = corePkg::addrWidth;
	localparam int waitLimit = 50; // Cycles, one instruction takes 5

	logic clk;
	logic rst;
	logic loadEn;
	logic [addrBits-1:0] loadAddr;
	logic [15:0] loadData;
	logic run;
	logic [addrBits:0] progLen;
	logic busy;
	logic done;
	logic resultValid;
	corePkg::dest_t resultDest;
	logic [corePkg::dataWidth-1:0] resultData;

	isaPkg::instrWord_t instrTab [maxRows]; // Program words
	corePkg::dest_t destTab [maxRows]; // Expected destination per row
	logic [corePkg::dataWidth-1:0] dataTab [maxRows]; // Expected value per row
	int numRows;
	int valueErrors;
	int timeoutErrors;
	integer seed;
	logic [7:0] rndImm; // Random LI immediate
	logic gotIt;

	clockGen u_clockGen (.clk);

	mips16Core u_mips16Core (.clk, .rst, .loadEn, .loadAddr, .loadData, .run, .progLen,
		.busy, .done, .resultValid, .resultDest, .resultData);

	//////////////////////////////////////////////////
	// Table and checks
	//////////////////////////////////////////////////

	task automatic addRow(input logic [15:0] word, input corePkg::dest_t dest,
		input logic [corePkg::dataWidth-1:0] data);
		instrTab[numRows] = word;
		destTab[numRows] = dest;
		dataTab[numRows] = data;
		numRows++; // Row index is also the PC
	endtask

	task automatic checkDest(input int row, input corePkg::dest_t got,
		input corePkg::dest_t exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("** Error at %0t: row %0d dest %s, expected %s", $time, row,
				got.name(), exp.name());
		end
	endtask

	task automatic checkData(input int row, input logic [corePkg::dataWidth-1:0] got,
		input logic [corePkg::dataWidth-1:0] exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("** Error at %0t: row %0d data %h, expected %h", $time, row, got, exp);
		end
	endtask

	// Status outputs busy and done
	task automatic checkFlag(input int row, input string what, input logic got,
		input logic exp);
		if (got !== exp)
		begin
			valueErrors++;
			$display("** Error at %0t: row %0d %s %b, expected %b", $time, row, what, got,
				exp);
		end
	endtask

	// Sampled on the falling edge, midway through the strobe
	task automatic waitResult(output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < waitLimit)
		begin
			@(negedge clk);
			cycles++;
			seen = resultValid;
		end
	endtask

	task automatic waitDone(output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < waitLimit)
		begin
			@(negedge clk);
			cycles++;
			seen = done;
		end
	endtask

	// Expected values worked out by hand, in program order
	task automatic buildTable();
		addRow(16'h6905, corePkg::dReg1, 16'h0005); // LI R1,5
		addRow(16'h49FD, corePkg::dReg1, 16'h0002); // ADDIU R1,-3
		addRow(16'h414F, corePkg::dReg2, 16'h0001); // ADDIU3 R2=R1-1
		addRow(16'h5903, corePkg::dT, 16'h0001); // SLTUI R1,3
		addRow(16'h6BF0, corePkg::dReg3, 16'h00F0); // LI R3,F0
		addRow(16'h6C3C, corePkg::dReg4, 16'h003C); // LI R4,3C
		addRow(16'hE395, corePkg::dReg5, 16'h012C); // ADDU R5=R3+R4
		addRow(16'hE47B, corePkg::dReg6, 16'hFF4C); // SUBU R6=R4-R3, wraps
		addRow(16'hEB8C, corePkg::dReg3, 16'h0030); // AND R3,R4
		addRow(16'hEA6D, corePkg::dReg2, 16'h0031); // OR R2,R3
		addRow(16'hEF8F, corePkg::dReg7, 16'hFFC3); // NOT R7,R4
		addRow(16'hE84B, corePkg::dReg0, 16'hFFCF); // NEG R0,R2
		addRow(16'h3188, corePkg::dReg1, 16'h00F0); // SLL R1,R4,2
		addRow(16'h31A0, corePkg::dReg1, 16'h2C00); // SLL R1,R5,0 means 8
		addRow(16'h36D3, corePkg::dReg6, 16'hFFF4); // SRA R6,R6,4
		addRow(16'h35E3, corePkg::dReg5, 16'hFFFF); // SRA R5,R7,8 all sign
		addRow(16'hEA6A, corePkg::dT, 16'h0001); // CMP R2,R3 unequal
		addRow(16'hEB6A, corePkg::dT, 16'h0000); // CMP R3,R3 equal
		addRow(16'hEE82, corePkg::dT, 16'h0001); // SLT -12 < 60
		addRow(16'hECC2, corePkg::dT, 16'h0000); // SLT R4,R6
		addRow(16'h5E10, corePkg::dT, 16'h0000); // SLTUI FFF4 < 10 unsigned
		addRow(16'h6480, corePkg::dSp, 16'h003C); // MTSP R4
		addRow(16'h63FC, corePkg::dSp, 16'h0038); // ADDSP -4
		addRow(16'hF701, corePkg::dIh, 16'hFFC3); // MTIH R7
		addRow(16'hF300, corePkg::dReg3, 16'hFFC3); // MFIH R3
		addRow(16'hE940, corePkg::dReg1, 16'(numRows + 1)); // MFPC R1
		addRow(16'h0800, corePkg::dNone, 16'h0000); // Idle word
		addRow(16'hFFFF, corePkg::dNone, 16'h0000); // Opcode 11111, unsupported
		addRow({8'h6D, rndImm}, corePkg::dReg5, {8'h00, rndImm}); // LI R5,random
		addRow(16'h7EA0, corePkg::dReg6, {8'h00, rndImm}); // MOVE R6,R5
	endtask

	//////////////////////////////////////////////////
	// Load, run, check
	//////////////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		run = 1'b0;
		progLen = '0;
		numRows = 0;
		valueErrors = 0;
		timeoutErrors = 0;
		seed = 32'h2ca5_9723;
		rndImm = 8'($random(seed));
		buildTable();

		repeat (5) @(posedge clk); // Reset for 5 cycles
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < numRows; i++)
		begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = addrBits'(i);
			loadData = instrTab[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		run = 1'b1; // One-cycle run strobe
		progLen = (addrBits+1)'(numRows);
		@(negedge clk);
		run = 1'b0;

		for (int i = 0; i < numRows && timeoutErrors == 0; i++)
		begin
			waitResult(gotIt);
			if (!gotIt)
			begin
				timeoutErrors++;
				$display("Timeout: no result for row %0d within %0d cycles", i, waitLimit);
			end
			else
			begin
				checkDest(i, resultDest, destTab[i]);
				if (destTab[i] != corePkg::dNone)
					checkData(i, resultData, dataTab[i]); // NOP data is undefined
				checkFlag(i, "busy", busy, 1'b1); // Still running at each commit
				checkFlag(i, "done", done, 1'b0);
			end
		end

		// done follows the last commit
		if (timeoutErrors == 0)
		begin
			waitDone(gotIt);
			if (!gotIt)
			begin
				timeoutErrors++;
				$display("Timeout: done did not pulse after the last result");
			end
			else
			begin
				@(negedge clk);
				checkFlag(numRows, "done", done, 1'b0); // Single-cycle pulse
				checkFlag(numRows, "busy", busy, 1'b0);
			end
		end

		$display("Summary: %0d rows, %0d value errors, %0d timeouts", numRows, valueErrors,
			timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* verilog/aluExecute.sv */
`timescale 1ns/10ps

module aluExecute
(
	input logic clk,
	input logic rst,
	decodeBus.sink bus,
	output corePkg::dest_t rdSelA,
	output corePkg::dest_t rdSelB,
	input logic [corePkg::dataWidth-1:0] rdDataA,
	input logic [corePkg::dataWidth-1:0] rdDataB,
	output logic resValid,
	output corePkg::dest_t resDest,
	output logic [corePkg::dataWidth-1:0] resData
);

	logic [corePkg::dataWidth-1:0] opA;
	logic [corePkg::dataWidth-1:0] opB;
	logic [corePkg::dataWidth-1:0] aluOut;
	logic [3:0] shAmt; // At most 8

	//////////////////////////////////////////////////
	// Operand fetch
	//////////////////////////////////////////////////

	assign rdSelA = bus.srcA; // Register file reads straight off the bus
	assign rdSelB = bus.srcB;

	// No A register means the PC is operand A
	assign opA = (bus.srcA == corePkg::dNone) ? bus.pcValue : rdDataA;
	assign opB = bus.useImm ? bus.imm : rdDataB;
	assign shAmt = opB[3:0];

	// 16-bit wraparound everywhere
	always_comb
	begin
		case (bus.aluOp)
			corePkg::aluAdd: aluOut = opA + opB;
			corePkg::aluSub: aluOut = opA - opB;
			corePkg::aluAnd: aluOut = opA & opB;
			corePkg::aluOr: aluOut = opA | opB;
			corePkg::aluNot: aluOut = ~opB;
			corePkg::aluNeg: aluOut = '0 - opB; // Two's complement
			corePkg::aluSll: aluOut = opA << shAmt;
			corePkg::aluSra: aluOut = $signed(opA) >>> shAmt; // Sign fill
			corePkg::aluPass: aluOut = opB;
			corePkg::aluCmp: aluOut = {{(corePkg::dataWidth-1){1'b0}}, opA != opB};
			corePkg::aluSlt:
				aluOut = {{(corePkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			corePkg::aluSltu: aluOut = {{(corePkg::dataWidth-1){1'b0}}, opA < opB};
			default: aluOut = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resValid <= 1'b0;
			resDest <= corePkg::dNone;
		end
		else
		begin
			resValid <= bus.valid;
			if (bus.valid)
				resDest <= bus.dest;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.valid)
			resData <= aluOut; // Payload only
	end

endmodule

/* verilog/corePkg.sv */
package corePkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////

	localparam int memDepth = 64; // Program words
	localparam int addrWidth = $clog2(memDepth);
	localparam int pcWidth = 16;
	localparam int dataWidth = 16;
	localparam int numRegs = 11; // R0-R7, SP, IH, T

	// Operations the execute stage knows
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot, // On operand B
		aluNeg, // On operand B
		aluSll,
		aluSra,
		aluPass, // Operand B unchanged
		aluCmp, // 1 when unequal
		aluSlt,
		aluSltu
	} aluOp_t;

	// Register selects, order matches storage index
	typedef enum logic [3:0] {
		dReg0, dReg1, dReg2, dReg3,
		dReg4, dReg5, dReg6, dReg7,
		dSp,
		dIh,
		dT,
		dNone // No write, reads as zero
	} dest_t;

endpackage

/* verilog/decodeBus.sv */
`timescale 1ns/10ps

interface decodeBus;

	logic valid; // One-cycle strobe
	corePkg::aluOp_t aluOp;
	corePkg::dest_t srcA; // Register file read selects
	corePkg::dest_t srcB;
	logic useImm; // B from imm instead of srcB
	logic [corePkg::dataWidth-1:0] imm; // Already extended
	logic [corePkg::pcWidth-1:0] pcValue; // Address of this instruction
	corePkg::dest_t dest;

	// Decode side
	modport source (
		output valid, aluOp, srcA, srcB, useImm, imm, pcValue, dest
	);

	// Execute side
	modport sink (
		input valid, aluOp, srcA, srcB, useImm, imm, pcValue, dest
	);

endinterface

/* verilog/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode
(
	input logic clk,
	input logic rst,
	input logic instrValid,
	input isaPkg::instrWord_t instr,
	input logic [corePkg::pcWidth-1:0] pc,
	decodeBus.source bus
);

	corePkg::aluOp_t nAluOp;
	corePkg::dest_t nSrcA;
	corePkg::dest_t nSrcB;
	corePkg::dest_t nDest;
	logic nUseImm;
	logic [15:0] nImm;
	logic [4:0] aluFn; // ALU group sub-function

	assign aluFn = {instr.rrr.rz, instr.rrr.func};

	// 3-bit register field to select
	function automatic corePkg::dest_t regSel(input logic [2:0] r);
		return corePkg::dest_t'({1'b0, r});
	endfunction

	//////////////////////////////////////////////////
	// Field decode
	//////////////////////////////////////////////////

	always_comb
	begin
		nAluOp = corePkg::aluPass; // Safe defaults give a NOP
		nSrcA = corePkg::dNone;
		nSrcB = corePkg::dNone;
		nDest = corePkg::dNone;
		nUseImm = 1'b0;
		nImm = '0;
		if (instr != isaPkg::nopWord)
		begin
			case (instr.ri.opcode)
				isaPkg::opAddiu:
				begin
					nAluOp = corePkg::aluAdd;
					nSrcA = regSel(instr.ri.rx);
					nUseImm = 1'b1;
					nImm = {{8{instr.ri.imm8[7]}}, instr.ri.imm8}; // Sign
					nDest = regSel(instr.ri.rx);
				end
				isaPkg::opAddiu3:
				begin
					nAluOp = corePkg::aluAdd;
					nSrcA = regSel(instr.rrr.rx);
					nUseImm = 1'b1;
					nImm = {{12{instr.ri.imm8[3]}}, instr.ri.imm8[3:0]}; // 4-bit sign
					nDest = regSel(instr.rrr.ry);
				end
				isaPkg::opLi, isaPkg::opSltui:
				begin
					nAluOp = (instr.ri.opcode == isaPkg::opLi) ? corePkg::aluPass
						: corePkg::aluSltu;
					nSrcA = regSel(instr.ri.rx);
					nUseImm = 1'b1;
					nImm = {8'h00, instr.ri.imm8}; // Zero
					nDest = (instr.ri.opcode == isaPkg::opLi) ? regSel(instr.ri.rx)
						: corePkg::dT;
				end
				isaPkg::opShift:
				if (instr.rrr.func == isaPkg::fnSll || instr.rrr.func == isaPkg::fnSra)
				begin
					nAluOp = (instr.rrr.func == isaPkg::fnSll) ? corePkg::aluSll
						: corePkg::aluSra;
					nSrcA = regSel(instr.rrr.ry);
					nUseImm = 1'b1;
					nImm = (instr.rrr.rz == 3'd0) ? 16'd8 : {13'd0, instr.rrr.rz}; // 0 is 8
					nDest = regSel(instr.rrr.rx);
				end
				isaPkg::opSp:
				if (instr.ri.rx == isaPkg::spAddsp)
				begin
					nAluOp = corePkg::aluAdd;
					nSrcA = corePkg::dSp;
					nUseImm = 1'b1;
					nImm = {{8{instr.ri.imm8[7]}}, instr.ri.imm8};
					nDest = corePkg::dSp;
				end
				else if (instr.ri.rx == isaPkg::spMtsp)
				begin
					nSrcB = regSel(instr.rrr.ry); // Source in bits 7:5
					nDest = corePkg::dSp;
				end
				isaPkg::opMove:
				begin
					nSrcB = regSel(instr.rrr.ry);
					nDest = regSel(instr.rrr.rx);
				end
				isaPkg::opRrr:
				if (instr.rrr.func == isaPkg::fnAddu || instr.rrr.func == isaPkg::fnSubu)
				begin
					nAluOp = (instr.rrr.func == isaPkg::fnAddu) ? corePkg::aluAdd
						: corePkg::aluSub;
					nSrcA = regSel(instr.rrr.rx);
					nSrcB = regSel(instr.rrr.ry);
					nDest = regSel(instr.rrr.rz);
				end
				isaPkg::opAlu:
				begin
					nSrcA = regSel(instr.rrr.rx);
					nSrcB = regSel(instr.rrr.ry);
					nDest = regSel(instr.rrr.rx); // Result back to rx
					case (aluFn)
						isaPkg::fnAnd: nAluOp = corePkg::aluAnd;
						isaPkg::fnOr: nAluOp = corePkg::aluOr;
						isaPkg::fnNot: nAluOp = corePkg::aluNot;
						isaPkg::fnNeg: nAluOp = corePkg::aluNeg;
						isaPkg::fnCmp:
						begin
							nAluOp = corePkg::aluCmp;
							nDest = corePkg::dT;
						end
						isaPkg::fnSlt:
						begin
							nAluOp = corePkg::aluSlt;
							nDest = corePkg::dT;
						end
						isaPkg::fnMfpc:
						if (instr.rrr.ry == 3'b010)
						begin
							nAluOp = corePkg::aluAdd;
							nSrcA = corePkg::dNone; // A falls back to the PC
							nUseImm = 1'b1;
							nImm = 16'd1;
						end
						else
							nDest = corePkg::dNone;
						default: nDest = corePkg::dNone;
					endcase
				end
				isaPkg::opIh:
				if (instr.ri.imm8 == isaPkg::ihMfih)
				begin
					nSrcB = corePkg::dIh;
					nDest = regSel(instr.ri.rx);
				end
				else if (instr.ri.imm8 == isaPkg::ihMtih)
				begin
					nSrcB = regSel(instr.ri.rx);
					nDest = corePkg::dIh;
				end
				default: nDest = corePkg::dNone; // Unsupported acts as NOP
			endcase
		end
	end

	// Control with reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bus.valid <= 1'b0;
			bus.dest <= corePkg::dNone;
		end
		else
		begin
			bus.valid <= instrValid;
			if (instrValid)
				bus.dest <= nDest;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			bus.aluOp <= nAluOp;
			bus.srcA <= nSrcA;
			bus.srcB <= nSrcB;
			bus.useImm <= nUseImm;
			bus.imm <= nImm;
			bus.pcValue <= pc;
		end
	end

endmodule

/* verilog/instrFetch.sv */
`timescale 1ns/10ps

module instrFetch
(
	input logic clk,
	input logic rst,
	input logic loadEn,
	input logic [corePkg::addrWidth-1:0] loadAddr,
	input logic [15:0] loadData,
	input logic run,
	input logic [corePkg::addrWidth:0] progLen,
	input logic commitDone,
	output logic busy,
	output logic instrValid,
	output isaPkg::instrWord_t instr,
	output logic [corePkg::pcWidth-1:0] pc
);

	isaPkg::instrWord_t progMem [corePkg::memDepth]; // Program store
	logic [corePkg::pcWidth-1:0] fetchPc; // Next word to issue
	logic [corePkg::pcWidth-1:0] lenReg; // Words in this run
	logic issue; // Read the word at fetchPc this cycle

	// Loads only while idle
	always_ff @(posedge clk)
	begin
		if (loadEn && !busy)
			progMem[loadAddr] <= loadData;
	end

	//////////////////////////////////////////////////
	// Run control, one word per commit
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			issue <= 1'b0;
			fetchPc <= '0;
			lenReg <= '0;
		end
		else
		begin
			issue <= 1'b0; // Strobe by default
			if (!busy && run && progLen != '0)
			begin
				busy <= 1'b1;
				issue <= 1'b1; // First issue next cycle
				fetchPc <= '0;
				lenReg <= {{(corePkg::pcWidth-corePkg::addrWidth-1){1'b0}}, progLen};
			end
			else if (issue)
				fetchPc <= fetchPc + 1'b1;
			else if (busy && commitDone)
			begin
				if (fetchPc == lenReg)
					busy <= 1'b0; // Last word committed
				else
					issue <= 1'b1;
			end
		end
	end

	// Word out one cycle after issue, idle word otherwise
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			instrValid <= 1'b0;
			instr <= isaPkg::nopWord;
			pc <= '0;
		end
		else
		begin
			instrValid <= issue;
			if (issue)
			begin
				instr <= progMem[fetchPc[corePkg::addrWidth-1:0]];
				pc <= fetchPc; // Travels with the word for MFPC
			end
			else
				instr <= isaPkg::nopWord;
		end
	end

endmodule

/* verilog/isaPkg.sv */
package isaPkg;

	//////////////////////////////////////////////////
	// Instruction word views
	//////////////////////////////////////////////////

	// Register-register format
	typedef struct packed {
		logic [4:0] opcode; // Major opcode
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz; // Also shift amount
		logic [1:0] func; // Minor function
	} rrrFmt_t;

	// Register-immediate format
	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [7:0] imm8; // Raw immediate field
	} riFmt_t;

	// Same 16 bits, read either way
	typedef union packed {
		rrrFmt_t rrr;
		riFmt_t ri;
	} instrWord_t;

	//////////////////////////////////////////////////
	// Major opcodes
	//////////////////////////////////////////////////

	localparam logic [4:0] opAddiu = 5'b01001; // rx += simm8
	localparam logic [4:0] opAddiu3 = 5'b01000; // ry = rx + simm4
	localparam logic [4:0] opLi = 5'b01101; // rx = imm8
	localparam logic [4:0] opSltui = 5'b01011; // T = rx < imm8
	localparam logic [4:0] opShift = 5'b00110; // SLL / SRA
	localparam logic [4:0] opSp = 5'b01100; // ADDSP / MTSP
	localparam logic [4:0] opMove = 5'b01111;
	localparam logic [4:0] opRrr = 5'b11100; // ADDU / SUBU
	localparam logic [4:0] opAlu = 5'b11101; // Two-register ALU group
	localparam logic [4:0] opIh = 5'b11110; // MFIH / MTIH

	// Minor codes inside the groups
	localparam logic [1:0] fnAddu = 2'b01;
	localparam logic [1:0] fnSubu = 2'b11;
	localparam logic [1:0] fnSll = 2'b00;
	localparam logic [1:0] fnSra = 2'b11;
	localparam logic [2:0] spAddsp = 3'b011; // Sits in the rx field
	localparam logic [2:0] spMtsp = 3'b100;
	localparam logic [7:0] ihMfih = 8'h00;
	localparam logic [7:0] ihMtih = 8'h01;

	// ALU group sub-functions, low five bits
	localparam logic [4:0] fnAnd = 5'b01100;
	localparam logic [4:0] fnOr = 5'b01101;
	localparam logic [4:0] fnNot = 5'b01111;
	localparam logic [4:0] fnNeg = 5'b01011;
	localparam logic [4:0] fnCmp = 5'b01010;
	localparam logic [4:0] fnSlt = 5'b00010;
	localparam logic [4:0] fnMfpc = 5'b00000; // With ry = 3'b010

	localparam logic [15:0] nopWord = 16'h0800; // Idle word between fetches

endpackage

/* verilog/mips16Core.sv */
`timescale 1ns/10ps

module mips16Core
(
	input logic clk,
	input logic rst,
	input logic loadEn,
	input logic [corePkg::addrWidth-1:0] loadAddr,
	input logic [15:0] loadData,
	input logic run,
	input logic [corePkg::addrWidth:0] progLen,
	output logic busy,
	output logic done,
	output logic resultValid,
	output corePkg::dest_t resultDest,
	output logic [corePkg::dataWidth-1:0] resultData
);

	decodeBus dBus (); // Decode to execute

	logic instrValid;
	isaPkg::instrWord_t instr;
	logic [corePkg::pcWidth-1:0] pc;
	corePkg::dest_t rdSelA;
	corePkg::dest_t rdSelB;
	logic [corePkg::dataWidth-1:0] rdDataA;
	logic [corePkg::dataWidth-1:0] rdDataB;
	logic resValid;
	corePkg::dest_t resDest;
	logic [corePkg::dataWidth-1:0] resData;
	logic wrEn;
	corePkg::dest_t wrSel;
	logic [corePkg::dataWidth-1:0] wrData;
	logic commitDone; // Paces the fetcher
	logic busyDly;

	//////////////////////////////////////////////////
	// Pipeline, one instruction at a time
	//////////////////////////////////////////////////

	instrFetch u_instrFetch (.clk, .rst, .loadEn, .loadAddr, .loadData, .run, .progLen,
		.commitDone, .busy, .instrValid, .instr, .pc);

	instrDecode u_instrDecode (.clk, .rst, .instrValid, .instr, .pc, .bus(dBus.source));

	regFile u_regFile (.clk, .rst, .rdSelA, .rdSelB, .rdDataA, .rdDataB,
		.wrEn, .wrSel, .wrData);

	aluExecute u_aluExecute (.clk, .rst, .bus(dBus.sink), .rdSelA, .rdSelB,
		.rdDataA, .rdDataB, .resValid, .resDest, .resData);

	writeBack u_writeBack (.clk, .rst, .resValid, .resDest, .resData, .wrEn, .wrSel,
		.wrData, .commitDone, .resultValid, .resultDest, .resultData);

	// done on the falling edge of busy
	always_ff @(posedge clk)
	begin
		if (rst)
			busyDly <= 1'b0;
		else
			busyDly <= busy;
	end

	assign done = busyDly && !busy;

endmodule

/* verilog/regFile.sv */
`timescale 1ns/10ps

module regFile
(
	input logic clk,
	input logic rst,
	input corePkg::dest_t rdSelA,
	input corePkg::dest_t rdSelB,
	output logic [corePkg::dataWidth-1:0] rdDataA,
	output logic [corePkg::dataWidth-1:0] rdDataB,
	input logic wrEn,
	input corePkg::dest_t wrSel,
	input logic [corePkg::dataWidth-1:0] wrData
);

	logic [corePkg::dataWidth-1:0] regs [corePkg::numRegs]; // R0-R7, SP, IH, T

	// Combinational reads, out of range and dNone read as zero
	assign rdDataA = (int'(rdSelA) < corePkg::numRegs) ? regs[rdSelA] : '0;
	assign rdDataB = (int'(rdSelB) < corePkg::numRegs) ? regs[rdSelB] : '0;

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < corePkg::numRegs; i++)
				regs[i] <= '0;
		end
		else if (wrEn && int'(wrSel) < corePkg::numRegs)
		begin
			if (wrSel == corePkg::dT)
				regs[wrSel] <= {{(corePkg::dataWidth-1){1'b0}}, wrData[0]}; // T keeps one bit
			else
				regs[wrSel] <= wrData;
		end
	end

endmodule

/* verilog/writeBack.sv */
`timescale 1ns/10ps

module writeBack
(
	input logic clk,
	input logic rst,
	input logic resValid,
	input corePkg::dest_t resDest,
	input logic [corePkg::dataWidth-1:0] resData,
	output logic wrEn,
	output corePkg::dest_t wrSel,
	output logic [corePkg::dataWidth-1:0] wrData,
	output logic commitDone,
	output logic resultValid,
	output corePkg::dest_t resultDest,
	output logic [corePkg::dataWidth-1:0] resultData
);

	// Register file takes the result at the end of this cycle
	assign wrEn = resValid && resDest != corePkg::dNone; // NOPs skip the write
	assign wrSel = resDest;
	assign wrData = resData;

	// Commit report, also for NOPs
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			commitDone <= 1'b0;
			resultValid <= 1'b0;
			resultDest <= corePkg::dNone;
		end
		else
		begin
			commitDone <= resValid; // Frees the fetcher
			resultValid <= resValid;
			if (resValid)
				resultDest <= resDest;
		end
	end

	always_ff @(posedge clk)
	begin
		if (resValid)
			resultData <= resData;
	end

endmodule
